// ==== src/net_stream_pkg.sv ====
////////////////////////////////////////////////////////////
// Widths and field positions of the TCP stack streams seen
// by the scatter monitor. Import this package wherever a
// stream port or a status field is decoded.
////////////////////////////////////////////////////////////

package net_stream_pkg;

  // stack data path
  localparam int data_width = 64;
  localparam int keep_width = data_width / 8;  // one keep bit per byte lane

  // open status reply
  // low 16 bits carry the session id
  localparam int open_status_width = 24;
  localparam int open_success_bit  = 16;  // set when the connection came up

  // tx status reply
  localparam int tx_status_width = 64;

  // two-bit error code at the top of the word
  // all zero means the write was taken by the stack
  localparam int tx_status_err_hi = 63;
  localparam int tx_status_err_lo = 62;

endpackage

// ==== src/bench_cfg_pkg.sv ====
////////////////////////////////////////////////////////////
// Counter and configuration widths of the scatter benchmark.
// The monitor outputs and the run setup ports are sized here.
////////////////////////////////////////////////////////////

package bench_cfg_pkg;

  // statistics counters
  localparam int byte_cnt_width  = 48;  // bytes per run, wide enough for long runs
  localparam int evt_cnt_width   = 32;  // packets, stalls, commands, status
  localparam int cycle_cnt_width = 64;  // execution cycles
  localparam int conn_cnt_width  = 8;   // connection handshakes

  // run configuration
  localparam int use_conn_width = 16;  // target number of open sessions
  localparam int pkg_num_width  = 32;  // tx packets that end a run

endpackage

// ==== src/stream_tap_if.sv ====
////////////////////////////////////////////////////////////
// Observed handshake and framing signals of one stack data
// stream. The top fills the source side, a byte counter
// reads the monitor side.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

interface stream_tap_if;
  import net_stream_pkg::*;

  logic                  valid;
  logic                  ready;
  logic [keep_width-1:0] keep;  // byte lane enables
  logic                  last;  // end of packet

  // counters only look
  modport monitor (input valid, input ready, input keep, input last);

  modport source (output valid, output ready, output keep, output last);

endinterface

// ==== src/run_control.sv ====
////////////////////////////////////////////////////////////
// Run controller of the scatter monitor. A rising ap_start
// opens a run and sends a one-cycle clear to all counters.
// The run closes with a one-cycle ap_done once the tx packet
// count reaches client_pkg_num.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module run_control (
  input  logic                                ap_clk,
  input  logic                                ap_rst_n,
  input  logic                                ap_start,
  input  logic [bench_cfg_pkg::pkg_num_width-1:0]   client_pkg_num,
  input  logic [bench_cfg_pkg::evt_cnt_width-1:0]   tx_pkt_count,
  output logic                                clear,
  output logic                                running,
  output logic                                ap_done,
  output logic                                ap_idle,
  output logic [bench_cfg_pkg::cycle_cnt_width-1:0] execution_cycles
);
  import bench_cfg_pkg::*;

  logic start_q;   // ap_start one edge back
  logic done_hit;  // packet target met in this cycle

  // start edge, combinational so counters clear on the same edge
  assign clear = ap_start & ~start_q;

  // a fresh start wins over a target left from the last run
  assign done_hit = running & ~clear & (client_pkg_num != '0) &
                    (pkg_num_width'(tx_pkt_count) == client_pkg_num);

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      start_q <= 1'b0;
      running <= 1'b0;
      ap_idle <= 1'b1;
      ap_done <= 1'b0;
    end else begin
      start_q <= ap_start;
      ap_done <= done_hit;  // single pulse, running drops with it
      if (clear) begin
        running <= 1'b1;
        ap_idle <= 1'b0;
      end else if (done_hit) begin
        running <= 1'b0;
        ap_idle <= 1'b1;  // idle comes back together with done
      end
    end
  end

  // execution time of the run
  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      execution_cycles <= '0;
    end else if (clear) begin
      execution_cycles <= '0;
    end else if (running) begin
      execution_cycles <= execution_cycles + 1'b1;
    end
  end

endmodule

// ==== src/stream_byte_counter.sv ====
////////////////////////////////////////////////////////////
// Byte, packet and stall statistics of one stack data stream.
// Used once for rx and once for tx. Counts in any run state
// and restarts from zero on clear.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module stream_byte_counter (
  input  logic                                    ap_clk,
  input  logic                                    ap_rst_n,
  input  logic                                    clear,
  stream_tap_if.monitor                           tap,
  output logic [bench_cfg_pkg::byte_cnt_width-1:0] byte_count,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]  pkt_count,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]  stall_cycles
);
  import net_stream_pkg::*;
  import bench_cfg_pkg::*;

  logic                      beat;        // accepted beat
  logic [keep_width-1:0]     keep_inc;
  logic                      contiguous;  // keep is a run of ones from lane 0
  logic [byte_cnt_width-1:0] beat_bytes;

  // number of set keep bits
  function automatic logic [byte_cnt_width-1:0] keep_bytes(input logic [keep_width-1:0] k);
    logic [byte_cnt_width-1:0] n;
    n = '0;
    for (int i = 0; i < keep_width; i++) begin
      n = n + byte_cnt_width'(k[i]);
    end
    return n;
  endfunction

  assign beat = tap.valid & tap.ready;

  // 2^n-1 pattern, a full keep wraps to zero here
  assign keep_inc   = tap.keep + 1'b1;
  assign contiguous = (tap.keep & keep_inc) == '0;
  assign beat_bytes = contiguous ? keep_bytes(tap.keep) : '0;  // holes add nothing

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      byte_count   <= '0;
      pkt_count    <= '0;
      stall_cycles <= '0;
    end else if (clear) begin
      byte_count   <= '0;  // beat on the clear edge is dropped
      pkt_count    <= '0;
      stall_cycles <= '0;
    end else begin
      if (beat) begin
        byte_count <= byte_count + beat_bytes;
      end
      if (beat && tap.last) begin
        pkt_count <= pkt_count + 1'b1;
      end
      if (tap.valid && !tap.ready) begin
        stall_cycles <= stall_cycles + 1'b1;  // stack back-pressure
      end
    end
  end

endmodule

// ==== src/tx_session_counter.sv ====
////////////////////////////////////////////////////////////
// Tx command and tx status statistics. Each accepted status
// is sorted into good or bad by its error code.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tx_session_counter (
  input  logic                                     ap_clk,
  input  logic                                     ap_rst_n,
  input  logic                                     clear,
  input  logic                                     tx_meta_valid,
  input  logic                                     tx_meta_ready,
  input  logic                                     tx_status_valid,
  input  logic                                     tx_status_ready,
  input  logic [net_stream_pkg::tx_status_width-1:0] tx_status_data,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]    cmd_count,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]    sts_good,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]    sts_bad
);
  import net_stream_pkg::*;

  logic sts_beat;
  logic sts_ok;  // error code all zero

  assign sts_beat = tx_status_valid & tx_status_ready;
  assign sts_ok   = tx_status_data[tx_status_err_hi:tx_status_err_lo] == '0;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      cmd_count <= '0;
      sts_good  <= '0;
      sts_bad   <= '0;
    end else if (clear) begin
      cmd_count <= '0;
      sts_good  <= '0;
      sts_bad   <= '0;
    end else begin
      if (tx_meta_valid && tx_meta_ready) begin
        cmd_count <= cmd_count + 1'b1;  // one per write request
      end
      if (sts_beat && sts_ok) begin
        sts_good <= sts_good + 1'b1;
      end
      if (sts_beat && !sts_ok) begin
        sts_bad <= sts_bad + 1'b1;  // stack refused the write
      end
    end
  end

endmodule

// ==== src/connection_counter.sv ====
////////////////////////////////////////////////////////////
// Connection setup statistics. Counts open requests, open
// replies and successful opens, and measures how long a run
// waits until use_conn sessions are up.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module connection_counter (
  input  logic                                       ap_clk,
  input  logic                                       ap_rst_n,
  input  logic                                       clear,
  input  logic                                       running,
  input  logic [bench_cfg_pkg::use_conn_width-1:0]    use_conn,
  input  logic                                       open_req_valid,
  input  logic                                       open_req_ready,
  input  logic                                       open_status_valid,
  input  logic                                       open_status_ready,
  input  logic [net_stream_pkg::open_status_width-1:0] open_status_data,
  output logic [bench_cfg_pkg::conn_cnt_width-1:0]    req_count,
  output logic [bench_cfg_pkg::conn_cnt_width-1:0]    status_count,
  output logic [bench_cfg_pkg::conn_cnt_width-1:0]    success_count,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]     open_cycles
);
  import net_stream_pkg::*;
  import bench_cfg_pkg::*;

  logic sts_beat;
  logic opening;  // sessions still missing

  assign sts_beat = open_status_valid & open_status_ready;
  assign opening  = use_conn_width'(success_count) != use_conn;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      req_count     <= '0;
      status_count  <= '0;
      success_count <= '0;
      open_cycles   <= '0;
    end else if (clear) begin
      req_count     <= '0;
      status_count  <= '0;
      success_count <= '0;
      open_cycles   <= '0;
    end else begin
      if (open_req_valid && open_req_ready) begin
        req_count <= req_count + 1'b1;
      end
      if (sts_beat) begin
        status_count <= status_count + 1'b1;  // any reply
      end
      if (sts_beat && open_status_data[open_success_bit]) begin
        success_count <= success_count + 1'b1;
      end
      if (running && opening) begin
        open_cycles <= open_cycles + 1'b1;  // open phase of the run
      end
    end
  end

endmodule

// ==== src/scatter_monitor_top.sv ====
////////////////////////////////////////////////////////////
// Top of the scatter benchmark monitor. Sits beside the TCP
// stack, observes its streams through plain ports and reports
// run control and statistics. Never drives a ready.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module scatter_monitor_top (
  input  logic                                         ap_clk,
  input  logic                                         ap_rst_n,
  input  logic                                         ap_start,
  input  logic [bench_cfg_pkg::pkg_num_width-1:0]        client_pkg_num,
  input  logic [bench_cfg_pkg::use_conn_width-1:0]       use_conn,
  input  logic                                         open_req_valid,
  input  logic                                         open_req_ready,
  input  logic                                         open_status_valid,
  input  logic                                         open_status_ready,
  input  logic [net_stream_pkg::open_status_width-1:0] open_status_data,
  input  logic                                         rx_data_valid,
  input  logic                                         rx_data_ready,
  input  logic                                         rx_data_last,
  input  logic [net_stream_pkg::keep_width-1:0]        rx_data_keep,
  input  logic                                         tx_data_valid,
  input  logic                                         tx_data_ready,
  input  logic                                         tx_data_last,
  input  logic [net_stream_pkg::keep_width-1:0]        tx_data_keep,
  input  logic                                         tx_meta_valid,
  input  logic                                         tx_meta_ready,
  input  logic                                         tx_status_valid,
  input  logic                                         tx_status_ready,
  input  logic [net_stream_pkg::tx_status_width-1:0]   tx_status_data,
  output logic                                         ap_done,
  output logic                                         ap_idle,
  output logic [bench_cfg_pkg::cycle_cnt_width-1:0]      execution_cycles,
  output logic [bench_cfg_pkg::byte_cnt_width-1:0]       rx_bytes,
  output logic [bench_cfg_pkg::byte_cnt_width-1:0]       tx_bytes,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]        rx_pkt_count,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]        tx_pkt_count,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]        rx_stall_cycles,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]        tx_stall_cycles,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]        tx_cmd_count,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]        tx_sts_good,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]        tx_sts_bad,
  output logic [bench_cfg_pkg::evt_cnt_width-1:0]        open_cycles,
  output logic [bench_cfg_pkg::conn_cnt_width-1:0]       open_req_count,
  output logic [bench_cfg_pkg::conn_cnt_width-1:0]       open_status_count,
  output logic [bench_cfg_pkg::conn_cnt_width-1:0]       open_success_count
);
  import bench_cfg_pkg::*;

  logic                     clear;    // start edge pulse
  logic                     running;
  logic [evt_cnt_width-1:0] tx_pkts;  // fed back for the done check

  stream_tap_if rx_tap ();
  stream_tap_if tx_tap ();

  // data streams into the taps
  assign rx_tap.valid = rx_data_valid;
  assign rx_tap.ready = rx_data_ready;
  assign rx_tap.keep  = rx_data_keep;
  assign rx_tap.last  = rx_data_last;
  assign tx_tap.valid = tx_data_valid;
  assign tx_tap.ready = tx_data_ready;
  assign tx_tap.keep  = tx_data_keep;
  assign tx_tap.last  = tx_data_last;

  assign tx_pkt_count = tx_pkts;

  run_control i_run_control (
    .ap_clk           (ap_clk),
    .ap_rst_n         (ap_rst_n),
    .ap_start         (ap_start),
    .client_pkg_num   (client_pkg_num),
    .tx_pkt_count     (tx_pkts),
    .clear            (clear),
    .running          (running),
    .ap_done          (ap_done),
    .ap_idle          (ap_idle),
    .execution_cycles (execution_cycles)
  );

  stream_byte_counter i_rx_bytes (
    .ap_clk       (ap_clk),
    .ap_rst_n     (ap_rst_n),
    .clear        (clear),
    .tap          (rx_tap.monitor),
    .byte_count   (rx_bytes),
    .pkt_count    (rx_pkt_count),
    .stall_cycles (rx_stall_cycles)
  );

  stream_byte_counter i_tx_bytes (
    .ap_clk       (ap_clk),
    .ap_rst_n     (ap_rst_n),
    .clear        (clear),
    .tap          (tx_tap.monitor),
    .byte_count   (tx_bytes),
    .pkt_count    (tx_pkts),
    .stall_cycles (tx_stall_cycles)
  );

  tx_session_counter i_tx_session_counter (
    .ap_clk          (ap_clk),
    .ap_rst_n        (ap_rst_n),
    .clear           (clear),
    .tx_meta_valid   (tx_meta_valid),
    .tx_meta_ready   (tx_meta_ready),
    .tx_status_valid (tx_status_valid),
    .tx_status_ready (tx_status_ready),
    .tx_status_data  (tx_status_data),
    .cmd_count       (tx_cmd_count),
    .sts_good        (tx_sts_good),
    .sts_bad         (tx_sts_bad)
  );

  connection_counter i_connection_counter (
    .ap_clk            (ap_clk),
    .ap_rst_n          (ap_rst_n),
    .clear             (clear),
    .running           (running),
    .use_conn          (use_conn),
    .open_req_valid    (open_req_valid),
    .open_req_ready    (open_req_ready),
    .open_status_valid (open_status_valid),
    .open_status_ready (open_status_ready),
    .open_status_data  (open_status_data),
    .req_count         (open_req_count),
    .status_count      (open_status_count),
    .success_count     (open_success_count),
    .open_cycles       (open_cycles)
  );

endmodule

// ==== verification/scatter_assertions.sv ====
////////////////////////////////////////////////////////////
// Run control rules, bound into every run_control instance.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module scatter_assertions (
  input logic                                      ap_clk,
  input logic                                      ap_rst_n,
  input logic                                      clear,
  input logic                                      running,
  input logic                                      ap_done,
  input logic                                      ap_idle,
  input logic [bench_cfg_pkg::cycle_cnt_width-1:0] execution_cycles
);

  // done is a single pulse
  done_single: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    ap_done |=> !ap_done) else $error("ap_done high two cycles in a row");

  idle_vs_run: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    !(ap_idle && running)) else $error("ap_idle and running both high");

  clear_zero: assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    clear |=> execution_cycles == '0) else $error("cycle count not zero after clear");

endmodule

// ==== verification/scatter_checker.sv ====
////////////////////////////////////////////////////////////
// Reference model and comparator of the scatter monitor.
// Rebuilds every output from the observed ports and checks
// the DUT on each falling edge. Reports one line per test.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module scatter_checker (
  input logic ap_clk, ap_rst_n, ap_start,
  input logic [bench_cfg_pkg::pkg_num_width-1:0] client_pkg_num,
  input logic [bench_cfg_pkg::use_conn_width-1:0] use_conn,
  input logic open_req_valid, open_req_ready, open_status_valid, open_status_ready,
  input logic [net_stream_pkg::open_status_width-1:0] open_status_data,
  input logic rx_data_valid, rx_data_ready, rx_data_last,
  input logic tx_data_valid, tx_data_ready, tx_data_last,
  input logic [net_stream_pkg::keep_width-1:0] rx_data_keep, tx_data_keep,
  input logic tx_meta_valid, tx_meta_ready, tx_status_valid, tx_status_ready,
  input logic [net_stream_pkg::tx_status_width-1:0] tx_status_data,
  input logic ap_done, ap_idle,
  input logic [bench_cfg_pkg::cycle_cnt_width-1:0] execution_cycles,
  input logic [bench_cfg_pkg::byte_cnt_width-1:0] rx_bytes, tx_bytes,
  input logic [bench_cfg_pkg::evt_cnt_width-1:0] rx_pkt_count, tx_pkt_count,
  input logic [bench_cfg_pkg::evt_cnt_width-1:0] rx_stall_cycles, tx_stall_cycles,
  input logic [bench_cfg_pkg::evt_cnt_width-1:0] tx_cmd_count, tx_sts_good, tx_sts_bad,
  input logic [bench_cfg_pkg::evt_cnt_width-1:0] open_cycles,
  input logic [bench_cfg_pkg::conn_cnt_width-1:0] open_req_count, open_status_count,
  input logic [bench_cfg_pkg::conn_cnt_width-1:0] open_success_count
);
  import net_stream_pkg::*;

  longint unsigned exec_m, rxb_m, txb_m, rxp_m, txp_m, rxs_m, txs_m;
  longint unsigned cmd_m, good_m, bad_m, ocyc_m, oreq_m, osts_m, osucc_m;
  bit    start_m, run_m, idle_m, done_m, clr, hit;
  bit    armed = 1'b0;  // a reset edge was seen
  string test_name = "reset";
  int    test_errs = 0;
  int    error_count = 0;
  int    tests_run = 0;
  int    tests_failed = 0;

  // lane 0 upward, a gap followed by a set lane gives zero bytes
  function automatic int keep_bytes(input logic [keep_width-1:0] k);
    int  n;
    bit  gap;
    n   = 0;
    gap = 0;
    for (int i = 0; i < keep_width; i++) begin
      if (k[i] && gap) return 0;
      if (k[i]) n++;
      else gap = 1;
    end
    return n;
  endfunction

  task automatic zero_counts();
    {exec_m, rxb_m, txb_m, rxp_m, txp_m, rxs_m, txs_m} <= '0;
    {cmd_m, good_m, bad_m, ocyc_m, oreq_m, osts_m, osucc_m} <= '0;
  endtask

  always @(posedge ap_clk) begin
    armed <= armed | !ap_rst_n;
    if (!ap_rst_n) begin
      {start_m, run_m, done_m} <= '0;
      idle_m <= 1'b1;
      zero_counts();
    end else begin
      clr = ap_start && !start_m;
      hit = run_m && !clr && client_pkg_num != 0 && txp_m == client_pkg_num;
      start_m <= ap_start;
      done_m  <= hit;
      if (clr) begin
        run_m  <= 1'b1;
        idle_m <= 1'b0;
      end else if (hit) begin
        run_m  <= 1'b0;
        idle_m <= 1'b1;
      end
      if (clr) begin
        zero_counts();  // same-cycle beats are lost
      end else begin
        if (run_m) exec_m <= exec_m + 1;
        if (rx_data_valid && rx_data_ready) rxb_m <= rxb_m + keep_bytes(rx_data_keep);
        if (rx_data_valid && rx_data_ready && rx_data_last) rxp_m <= rxp_m + 1;
        if (rx_data_valid && !rx_data_ready) rxs_m <= rxs_m + 1;
        if (tx_data_valid && tx_data_ready) txb_m <= txb_m + keep_bytes(tx_data_keep);
        if (tx_data_valid && tx_data_ready && tx_data_last) txp_m <= txp_m + 1;
        if (tx_data_valid && !tx_data_ready) txs_m <= txs_m + 1;
        if (tx_meta_valid && tx_meta_ready) cmd_m <= cmd_m + 1;
        if (tx_status_valid && tx_status_ready) begin
          if (tx_status_data[tx_status_err_hi:tx_status_err_lo] == 0) good_m <= good_m + 1;
          else bad_m <= bad_m + 1;
        end
        if (open_req_valid && open_req_ready) oreq_m <= oreq_m + 1;
        if (open_status_valid && open_status_ready) begin
          osts_m <= osts_m + 1;
          if (open_status_data[open_success_bit]) osucc_m <= osucc_m + 1;
        end
        if (run_m && osucc_m != use_conn) ocyc_m <= ocyc_m + 1;  // still opening
      end
    end
  end

  task automatic compare(input string sig, input longint unsigned exp, input longint unsigned act);
    if (exp !== act) begin
      $display("** Error %s: %s expected %0d, actual %0d", test_name, sig, exp, act);
      test_errs++;
      error_count++;
    end
  endtask

  // outputs are settled half a cycle after the edge
  always @(negedge ap_clk) begin
    if (armed) begin
      compare("ap_done", done_m, ap_done);
      compare("ap_idle", idle_m, ap_idle);
      compare("execution_cycles", exec_m, execution_cycles);
      compare("rx_bytes", rxb_m, rx_bytes);
      compare("tx_bytes", txb_m, tx_bytes);
      compare("rx_pkt_count", rxp_m, rx_pkt_count);
      compare("tx_pkt_count", txp_m, tx_pkt_count);
      compare("rx_stall_cycles", rxs_m, rx_stall_cycles);
      compare("tx_stall_cycles", txs_m, tx_stall_cycles);
      compare("tx_cmd_count", cmd_m, tx_cmd_count);
      compare("tx_sts_good", good_m, tx_sts_good);
      compare("tx_sts_bad", bad_m, tx_sts_bad);
      compare("open_cycles", ocyc_m, open_cycles);
      compare("open_req_count", oreq_m, open_req_count);
      compare("open_status_count", osts_m, open_status_count);
      compare("open_success_count", osucc_m, open_success_count);
    end
  end

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %s: %s, %0d mismatches", test_name, (test_errs == 0) ? "ok" : "FAILED",
             test_errs);
  endtask

  task automatic report_totals();
    $display("tests run %0d, tests failed %0d, mismatches %0d", tests_run, tests_failed,
             error_count);
  endtask

endmodule

// ==== verification/tb_scatter_monitor.sv ====
////////////////////////////////////////////////////////////
// Testbench of the scatter monitor. Applies a table of tests,
// one start edge each, with beats on the observed streams and
// random stall cycles. The checker mirrors the counting rules
// and compares. This module ends the run.
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_scatter_monitor;
  import net_stream_pkg::*;
  import bench_cfg_pkg::*;

  // stream codes of the table
  localparam int s_rx   = 0;
  localparam int s_tx   = 1;
  localparam int s_meta = 2;
  localparam int s_tsts = 3;
  localparam int s_oreq = 4;
  localparam int s_osts = 5;

  typedef struct {
    int                    stream;
    logic [keep_width-1:0] keep;
    bit                    last;
    bit                    ready;
    logic [63:0]           sts;  // open or tx status word
  } beat_t;

  typedef struct {
    string name;
    int    pkg;
    int    conn;
    int    first;  // index of the first beat
    int    count;
  } test_t;

  logic ap_clk, ap_rst_n, ap_start;
  logic [pkg_num_width-1:0] client_pkg_num;
  logic [use_conn_width-1:0] use_conn;
  logic open_req_valid, open_req_ready, open_status_valid, open_status_ready;
  logic [open_status_width-1:0] open_status_data;
  logic rx_data_valid, rx_data_ready, rx_data_last;
  logic tx_data_valid, tx_data_ready, tx_data_last;
  logic [keep_width-1:0] rx_data_keep, tx_data_keep;
  logic tx_meta_valid, tx_meta_ready, tx_status_valid, tx_status_ready;
  logic [tx_status_width-1:0] tx_status_data;
  logic ap_done, ap_idle;
  logic [cycle_cnt_width-1:0] execution_cycles;
  logic [byte_cnt_width-1:0] rx_bytes, tx_bytes;
  logic [evt_cnt_width-1:0] rx_pkt_count, tx_pkt_count, rx_stall_cycles, tx_stall_cycles;
  logic [evt_cnt_width-1:0] tx_cmd_count, tx_sts_good, tx_sts_bad, open_cycles;
  logic [conn_cnt_width-1:0] open_req_count, open_status_count, open_success_count;

  beat_t beats[$];
  test_t tests[$];
  int    seed        = 32'h54c6;
  int    cycle_cnt   = 0;
  int    cycle_limit = 0;  // zero until the table is built

  initial ap_clk = 1'b0;
  always #2 ap_clk = ~ap_clk;  // 4 ns period

  scatter_monitor_top i_scatter_monitor_top (.*);
  scatter_checker     i_checker (.*);

  bind run_control scatter_assertions i_run_assertions (.*);

  task automatic open_test(input string n, input int p, input int c);
    tests.push_back('{n, p, c, beats.size(), 0});
  endtask

  task automatic add(input int s, input logic [keep_width-1:0] k, input bit l, input bit r,
                     input logic [63:0] st);
    beats.push_back('{s, k, l, r, st});
    tests[tests.size()-1].count++;
  endtask

  task automatic idle_inputs();
    {open_req_valid, open_req_ready, open_status_valid, open_status_ready} = '0;
    {rx_data_valid, rx_data_ready, rx_data_last, rx_data_keep} = '0;
    {tx_data_valid, tx_data_ready, tx_data_last, tx_data_keep} = '0;
    {tx_meta_valid, tx_meta_ready, tx_status_valid, tx_status_ready} = '0;
    open_status_data = '0;
    tx_status_data   = '0;
  endtask

  // one beat on its stream with all else quiet
  task automatic drive_beat(input beat_t b, input bit rdy);
    idle_inputs();
    case (b.stream)
      s_rx: {rx_data_valid, rx_data_ready, rx_data_keep, rx_data_last} =
              {1'b1, rdy, b.keep, b.last};
      s_tx: {tx_data_valid, tx_data_ready, tx_data_keep, tx_data_last} =
              {1'b1, rdy, b.keep, b.last};
      s_meta: {tx_meta_valid, tx_meta_ready} = {1'b1, rdy};
      s_tsts: begin
        {tx_status_valid, tx_status_ready} = {1'b1, rdy};
        tx_status_data = b.sts;
      end
      s_oreq: {open_req_valid, open_req_ready} = {1'b1, rdy};
      default: begin
        {open_status_valid, open_status_ready} = {1'b1, rdy};
        open_status_data = b.sts[open_status_width-1:0];
      end
    endcase
  endtask

  always @(posedge ap_clk) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    int total;
    idle_inputs();
    {ap_start, client_pkg_num, use_conn} = '0;
    ap_rst_n = 1'b0;
    open_test("rx_keeps", 0, 0);
    add(s_rx, 8'hff, 0, 1, 0);
    add(s_rx, 8'h0f, 1, 1, 0);
    add(s_rx, 8'h05, 1, 1, 0);  // hole in keep
    add(s_rx, 8'h3f, 0, 0, 0);  // stall only
    add(s_rx, 8'h01, 1, 1, 0);
    add(s_tx, 8'h7f, 0, 1, 0);
    open_test("tx_done", 2, 1);
    add(s_oreq, 0, 0, 1, 0);
    add(s_osts, 0, 0, 1, 64'h1_0003);  // success bit set
    add(s_tx, 8'hff, 1, 1, 0);
    add(s_tx, 8'h03, 1, 1, 0);
    open_test("tx_status", 1, 2);
    add(s_meta, 0, 0, 1, 0);
    add(s_meta, 0, 0, 0, 0);
    add(s_tsts, 0, 0, 1, 64'h0000_0000_0000_1234);
    add(s_tsts, 0, 0, 1, 64'h4000_0000_0000_0000);
    add(s_tsts, 0, 0, 1, 64'hc000_0000_0000_0001);
    add(s_osts, 0, 0, 1, 64'h0_0005);  // refused open
    add(s_osts, 0, 0, 1, 64'h1_0006);
    add(s_tx, 8'h0f, 1, 1, 0);
    open_test("zero_target", 0, 0);
    add(s_tx, 8'hff, 1, 1, 0);
    add(s_tx, 8'h0f, 0, 0, 0);  // tx stall only
    add(s_tx, 8'h81, 1, 1, 0);
    add(s_meta, 0, 0, 1, 0);
    total = 0;
    foreach (tests[t]) total += tests[t].count + 20;
    cycle_limit = total * 2;
    repeat (5) @(negedge ap_clk);
    ap_rst_n = 1'b1;
    @(negedge ap_clk);
    foreach (tests[t]) begin
      @(posedge ap_clk);
      i_checker.begin_test(tests[t].name);
      @(negedge ap_clk);
      client_pkg_num = tests[t].pkg;
      use_conn       = tests[t].conn;
      ap_start       = 1'b1;  // start edge clears everything
      @(negedge ap_clk);
      for (int i = tests[t].first; i < tests[t].first + tests[t].count; i++) begin
        if (($random(seed) & 3) == 0) begin
          drive_beat(beats[i], 1'b0);  // random back-pressure gap
          @(negedge ap_clk);
        end
        drive_beat(beats[i], beats[i].ready);
        @(negedge ap_clk);
      end
      idle_inputs();
      if (tests[t].pkg != 0) begin
        while (!ap_done) @(negedge ap_clk);
      end
      repeat (2) @(negedge ap_clk);
      ap_start = 1'b0;
      @(posedge ap_clk);
      i_checker.end_test();
    end
    i_checker.report_totals();
    if (i_checker.error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
src/net_stream_pkg.sv
src/bench_cfg_pkg.sv
src/stream_tap_if.sv
src/run_control.sv
src/stream_byte_counter.sv
src/tx_session_counter.sv
src/connection_counter.sv
src/scatter_monitor_top.sv
verification/scatter_assertions.sv
verification/scatter_checker.sv
verification/tb_scatter_monitor.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the scatter monitor testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_scatter_monitor -f tb.f -o sim_scatter
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_scatter > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
exit 0
